/* flist.f */
hdl/sa_pkg.sv
hdl/act_skew.sv
hdl/sa_pe.sv
hdl/sa_array.sv
hdl/psum_deskew.sv
hdl/requant.sv
hdl/sa_top.sv
verif/sa_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the systolic array testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module sa_tb -f flist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vsa_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "sim passed" sim.log; then
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi

/* verif/sa_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sa_tb;
  import sa_pkg::*;

  // ~110 vectors, 25 row loads, drains and idle gaps stay well below this
  localparam int MAX_CYCLES = 2000;
  // sample edge to out_valid
  localparam int LATENCY = SA_ROWS + SA_COLS - 1;

  logic     clk;
  logic     rst;
  logic     wt_load;
  row_idx_t wt_row;
  wt_row_t  wt_data;
  logic     in_valid;
  act_vec_t in_data;
  shift_t   shift;
  logic     relu_en;
  logic     out_valid;
  out_vec_t out_data;

  int          cyc = 0;
  int          errors = 0;
  int          out_count = 0;
  logic [31:0] lfsr_state = 32'h56b2_429b;
  // reference state mirrored from what was driven
  int          w_model [SA_ROWS][SA_COLS];
  int          cur_shift;
  bit          cur_relu;
  // expected results and their due cycles
  out_vec_t    exp_q [$];
  int          cyc_q [$];
  out_vec_t    mon_data;
  int          mon_cyc;

  sa_top dut (
    .clk       (clk),
    .rst       (rst),
    .wt_load   (wt_load),
    .wt_row    (wt_row),
    .wt_data   (wt_data),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .shift     (shift),
    .relu_en   (relu_en),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  always #5 clk = ~clk;

  ////////////////////
  // cycle limit
  ////////////////////
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d results pending", cyc, exp_q.size());
      $display("errors: %0d, outputs seen: %0d", errors + 1, out_count);
      $display("sim failed");
      $finish;
    end
  end

  ////////////////////
  // stimulus helpers
  ////////////////////
  // 32 bit fibonacci, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // element r lands in slice r
  function automatic act_vec_t make_vec(int a0, int a1, int a2, int a3);
    return {act_t'(a3), act_t'(a2), act_t'(a1), act_t'(a0)};
  endfunction

  ////////////////////
  // reference model
  ////////////////////
  // round half up, shift, relu, clamp to signed 8 bits
  function automatic int requant_ref(longint s);
    longint v;
    v = s;
    if (cur_shift != 0) begin
      v = v + (longint'(1) << (cur_shift - 1));
    end
    v = v >>> cur_shift;
    if (cur_relu && v < 0) begin
      v = 0;
    end
    if (v > 127) begin
      v = 127;
    end else if (v < -128) begin
      v = -128;
    end
    return int'(v);
  endfunction

  // y[c] = sum over r of x[r] * w[r][c]
  function automatic out_vec_t expect_vec(act_vec_t x);
    out_vec_t y;
    longint   acc;
    y = '0;
    for (int c = 0; c < SA_COLS; c++) begin
      acc = 0;
      for (int r = 0; r < SA_ROWS; r++) begin
        acc += longint'(act_t'(x[r*ACT_W +: ACT_W])) * longint'(w_model[r][c]);
      end
      y[c*OUT_W +: OUT_W] = OUT_W'(requant_ref(acc));
    end
    return y;
  endfunction

  task automatic compare(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %s got %0h expected %0h at cycle %0d", name, got, exp, cyc);
    end
  endtask

  ////////////////////
  // output monitor
  ////////////////////
  always @(negedge clk) begin
    if (!rst && out_valid === 1'b1) begin
      out_count++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("unexpected output with no vector in flight at cycle %0d", cyc);
      end else begin
        mon_data = exp_q.pop_front();
        mon_cyc  = cyc_q.pop_front();
        compare("out_data", out_data, mon_data);
        compare("out_valid cycle", cyc, mon_cyc);
      end
    end
  end

  ////////////////////
  // drive tasks
  ////////////////////
  task automatic load_row(int row, wt_row_t data);
    @(negedge clk);
    wt_load = 1'b1;
    wt_row  = row_idx_t'(row);
    wt_data = data;
    for (int c = 0; c < SA_COLS; c++) begin
      w_model[row][c] = int'(wt_t'(data[c*WT_W +: WT_W]));
    end
    @(negedge clk);
    wt_load = 1'b0;
  endtask

  task automatic load_identity();
    wt_row_t data;
    for (int r = 0; r < SA_ROWS; r++) begin
      data = '0;
      data[r*WT_W +: WT_W] = 8'sd1;
      load_row(r, data);
    end
  endtask

  task automatic load_random();
    for (int r = 0; r < SA_ROWS; r++) begin
      load_row(r, wt_row_t'(rand_bits(SA_COLS * WT_W)));
    end
  endtask

  // only between bursts, requant reads these live
  task automatic set_mode(int sh, bit relu);
    @(negedge clk);
    shift     = shift_t'(sh);
    relu_en   = relu;
    cur_shift = sh;
    cur_relu  = relu;
  endtask

  // in_valid stays high until the next drive
  // sampled on the rising edge after this negedge
  task automatic send_vec(act_vec_t x);
    @(negedge clk);
    in_valid = 1'b1;
    in_data  = x;
    exp_q.push_back(expect_vec(x));
    cyc_q.push_back(cyc + 1 + LATENCY);
  endtask

  task automatic idle_cycles(int n);
    repeat (n) begin
      @(negedge clk);
      in_valid = 1'b0;
    end
  endtask

  task automatic wait_drain();
    idle_cycles(1);
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    idle_cycles(2);
  endtask

  ////////////////////
  // tests
  ////////////////////
  task automatic test_latency();
    int start;
    set_mode(0, 1'b0);
    load_identity();
    // nothing may come out before the first vector
    repeat (6) begin
      @(negedge clk);
      compare("out_valid", out_valid, 0);
    end
    start = out_count;
    send_vec(make_vec(5, -7, 127, -128));
    wait_drain();
    compare("output count", out_count - start, 1);
  endtask

  task automatic test_random_burst();
    int start;
    load_random();
    set_mode(7, 1'b0);
    start = out_count;
    for (int i = 0; i < 64; i++) begin
      send_vec(act_vec_t'(rand_bits(SA_ROWS * ACT_W)));
    end
    wait_drain();
    compare("output count", out_count - start, 64);
  endtask

  // identity weights, so each sum is the input element
  task automatic test_rounding();
    load_identity();
    set_mode(1, 1'b0);
    send_vec(make_vec(3, -3, 1, -1));
    send_vec(make_vec(5, -5, 0, 2));
    wait_drain();
    set_mode(4, 1'b0);
    send_vec(make_vec(24, -24, 8, -8));
    send_vec(make_vec(23, -25, 127, -128));
    wait_drain();
    set_mode(7, 1'b0);
    send_vec(make_vec(64, -64, -65, 63));
    send_vec(make_vec(127, -128, 0, 65));
    wait_drain();
  endtask

  task automatic test_saturation();
    for (int r = 0; r < SA_ROWS; r++) begin
      load_row(r, {SA_COLS{8'sd127}});
    end
    set_mode(0, 1'b0);
    send_vec(make_vec(127, 127, 127, 127));
    send_vec(make_vec(-128, -128, -128, -128));
    send_vec(make_vec(1, 0, 0, 0));
    send_vec(make_vec(-1, 0, 0, 0));
    wait_drain();
  endtask

  task automatic test_relu();
    load_identity();
    set_mode(0, 1'b1);
    send_vec(make_vec(-5, 5, -128, 127));
    send_vec(make_vec(0, -1, 1, -2));
    wait_drain();
    set_mode(0, 1'b0);
  endtask

  task automatic test_reload_gapped();
    int start;
    load_random();
    set_mode(6, 1'b0);
    for (int i = 0; i < 8; i++) begin
      send_vec(act_vec_t'(rand_bits(SA_ROWS * ACT_W)));
    end
    wait_drain();
    // new row 2 only
    load_row(2, wt_row_t'(rand_bits(SA_COLS * WT_W)));
    start = out_count;
    for (int i = 0; i < 24; i++) begin
      send_vec(act_vec_t'(rand_bits(SA_ROWS * ACT_W)));
      idle_cycles(int'(rand_bits(2)));
    end
    wait_drain();
    compare("output count", out_count - start, 24);
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    wt_load   = 1'b0;
    wt_row    = '0;
    wt_data   = '0;
    in_valid  = 1'b0;
    in_data   = '0;
    shift     = '0;
    relu_en   = 1'b0;
    cur_shift = 0;
    cur_relu  = 1'b0;
    repeat (4) @(negedge clk);
    rst = 1'b0;

    test_latency();
    test_random_burst();
    test_rounding();
    test_saturation();
    test_relu();
    test_reload_gapped();

    $display("errors: %0d, outputs seen: %0d", errors, out_count);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/sa_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sa_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             wt_load,
  input  sa_pkg::row_idx_t wt_row,
  input  sa_pkg::wt_row_t  wt_data,
  input  logic             in_valid,
  input  sa_pkg::act_vec_t in_data,
  input  sa_pkg::shift_t   shift,
  input  logic             relu_en,
  output logic             out_valid,
  output sa_pkg::out_vec_t out_data
);
  import sa_pkg::*;

  // skewed activations into the array
  logic [SA_ROWS-1:0] skew_valid;
  act_vec_t           skew_data;
  // staggered bottom row sums
  logic [SA_COLS-1:0] col_valid;
  acc_vec_t           col_sum;
  // realigned sums
  logic               aligned_valid;
  acc_vec_t           aligned_sum;

  ////////////////////
  // datapath chain
  ////////////////////
  act_skew u_skew (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .skew_valid (skew_valid),
    .skew_data  (skew_data)
  );

  sa_array u_array (
    .clk       (clk),
    .rst       (rst),
    .wt_load   (wt_load),
    .wt_row    (wt_row),
    .wt_data   (wt_data),
    .row_valid (skew_valid),
    .row_data  (skew_data),
    .col_valid (col_valid),
    .col_sum   (col_sum)
  );

  psum_deskew u_deskew (
    .clk           (clk),
    .col_valid     (col_valid),
    .col_sum       (col_sum),
    .aligned_valid (aligned_valid),
    .aligned_sum   (aligned_sum)
  );

  // one more register, total latency rows + cols - 1
  requant u_requant (
    .clk       (clk),
    .rst       (rst),
    .shift     (shift),
    .relu_en   (relu_en),
    .sum_valid (aligned_valid),
    .sum       (aligned_sum),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

endmodule

`default_nettype wire

/* hdl/requant.sv */
`timescale 1ns/1ps
`default_nettype none

module requant (
  input  logic             clk,
  input  logic             rst,
  input  sa_pkg::shift_t   shift,
  input  logic             relu_en,
  input  logic             sum_valid,
  input  sa_pkg::acc_vec_t sum,
  output logic             out_valid,
  output sa_pkg::out_vec_t out_data
);
  import sa_pkg::*;

  out_vec_t out_next;

  for (genvar c = 0; c < SA_COLS; c++) begin : g_col
    logic signed [RND_W-1:0] sum_ext;
    logic signed [RND_W-1:0] half;
    logic signed [RND_W-1:0] shifted;
    logic signed [OUT_W-1:0] res;

    always_comb begin
      // sign extend into the wide rounding path
      sum_ext = acc_t'(sum[c*ACC_W +: ACC_W]);
      // half lsb, round half up
      half = '0;
      if (shift != '0) begin
        half[shift - 1'b1] = 1'b1;
      end
      shifted = (sum_ext + half) >>> shift;
      // relu then clamp to signed out range
      if (relu_en && (shifted < 0)) begin
        res = '0;
      end else if (shifted > OUT_MAX) begin
        res = OUT_W'(OUT_MAX);
      end else if (shifted < OUT_MIN) begin
        res = OUT_W'(OUT_MIN);
      end else begin
        res = shifted[OUT_W-1:0];
      end
    end

    assign out_next[c*OUT_W +: OUT_W] = res;
  end

  ////////////////////
  // output register
  ////////////////////
  always_ff @(posedge clk) begin
    if (sum_valid) begin
      out_data <= out_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= sum_valid;
    end
  end

endmodule

`default_nettype wire

/* hdl/psum_deskew.sv */
`timescale 1ns/1ps
`default_nettype none

module psum_deskew (
  input  logic                       clk,
  input  logic [sa_pkg::SA_COLS-1:0] col_valid,
  input  sa_pkg::acc_vec_t           col_sum,
  output logic                       aligned_valid,
  output sa_pkg::acc_vec_t           aligned_sum
);
  import sa_pkg::*;

  ////////////////////
  // delay triangle
  ////////////////////
  // column c waits SA_COLS-1-c cycles for the last column
  for (genvar c = 0; c < SA_COLS; c++) begin : g_col
    if (c == SA_COLS - 1) begin : g_pass
      // last column already arrives last
      assign aligned_sum[c*ACC_W +: ACC_W] = col_sum[c*ACC_W +: ACC_W];
    end else begin : g_dly
      acc_t dly [SA_COLS-1-c];

      // plain data registers
      always_ff @(posedge clk) begin
        dly[0] <= acc_t'(col_sum[c*ACC_W +: ACC_W]);
        for (int i = 1; i < SA_COLS - 1 - c; i++) begin
          dly[i] <= dly[i-1];
        end
      end

      // oldest tap
      assign aligned_sum[c*ACC_W +: ACC_W] = dly[SA_COLS-2-c];
    end
  end

  // last column valid marks the aligned slot
  // earlier column valids are implied by it
  assign aligned_valid = col_valid[SA_COLS-1];

endmodule

`default_nettype wire

/* hdl/sa_array.sv */
`timescale 1ns/1ps
`default_nettype none

module sa_array (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       wt_load,
  input  sa_pkg::row_idx_t           wt_row,
  input  sa_pkg::wt_row_t            wt_data,
  input  logic [sa_pkg::SA_ROWS-1:0] row_valid,
  input  sa_pkg::act_vec_t           row_data,
  output logic [sa_pkg::SA_COLS-1:0] col_valid,
  output sa_pkg::acc_vec_t           col_sum
);
  import sa_pkg::*;

  // horizontal activation links, one extra column past the edge
  act_t act_bus  [SA_ROWS][SA_COLS+1];
  logic act_vld  [SA_ROWS][SA_COLS+1];
  // vertical partial sum links, row 0 is the top tie-off
  acc_t psum_bus [SA_ROWS+1][SA_COLS];
  logic psum_vld [SA_ROWS+1][SA_COLS];
  logic [SA_ROWS-1:0] row_we;

  for (genvar r = 0; r < SA_ROWS; r++) begin : g_row
    // row select decode
    assign row_we[r] = wt_load && (wt_row == row_idx_t'(r));

    // left edge fed by skewed activations
    assign act_bus[r][0] = act_t'(row_data[r*ACT_W +: ACT_W]);
    assign act_vld[r][0] = row_valid[r];

    for (genvar c = 0; c < SA_COLS; c++) begin : g_col
      sa_pe u_pe (
        .clk            (clk),
        .rst            (rst),
        .wt_we          (row_we[r]),
        .wt_in          (wt_t'(wt_data[c*WT_W +: WT_W])),
        .act_in         (act_bus[r][c]),
        .act_valid_in   (act_vld[r][c]),
        .psum_in        (psum_bus[r][c]),
        .psum_valid_in  (psum_vld[r][c]),
        .act_out        (act_bus[r][c+1]),
        .act_valid_out  (act_vld[r][c+1]),
        .psum_out       (psum_bus[r+1][c]),
        .psum_valid_out (psum_vld[r+1][c])
      );
    end
  end

  ////////////////////
  // column edges
  ////////////////////
  for (genvar c = 0; c < SA_COLS; c++) begin : g_edge
    // top row starts a fresh sum
    assign psum_bus[0][c] = '0;
    assign psum_vld[0][c] = 1'b0;

    // bottom row, column c lags column c-1 by one cycle
    assign col_sum[c*ACC_W +: ACC_W] = psum_bus[SA_ROWS][c];
    assign col_valid[c]              = psum_vld[SA_ROWS][c];
  end

endmodule

`default_nettype wire

/* hdl/sa_pe.sv */
`timescale 1ns/1ps
`default_nettype none

module sa_pe (
  input  logic         clk,
  input  logic         rst,
  input  logic         wt_we,
  input  sa_pkg::wt_t  wt_in,
  input  sa_pkg::act_t act_in,
  input  logic         act_valid_in,
  input  sa_pkg::acc_t psum_in,
  input  logic         psum_valid_in,
  output sa_pkg::act_t act_out,
  output logic         act_valid_out,
  output sa_pkg::acc_t psum_out,
  output logic         psum_valid_out
);
  import sa_pkg::*;

  wt_t  weight;
  acc_t prod;
  logic valid_q;

  ////////////////////
  // stationary weight
  ////////////////////
  always_ff @(posedge clk) begin
    if (wt_we) begin
      weight <= wt_in;
    end
  end

  // signed 8x8, sign extended to accumulator width
  assign prod = acc_t'(act_in) * acc_t'(weight);

  ////////////////////
  // mac and forward
  ////////////////////
  // sum from above arrives in the same slot as act_in
  always_ff @(posedge clk) begin
    psum_out <= psum_in + prod;
    act_out  <= act_in;
  end

  // one valid bit serves both directions
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= act_valid_in;
    end
  end

  assign act_valid_out  = valid_q;
  assign psum_valid_out = valid_q;

endmodule

`default_nettype wire

/* hdl/act_skew.sv */
`timescale 1ns/1ps
`default_nettype none

module act_skew (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       in_valid,
  input  sa_pkg::act_vec_t           in_data,
  output logic [sa_pkg::SA_ROWS-1:0] skew_valid,
  output sa_pkg::act_vec_t           skew_data
);
  import sa_pkg::*;

  // row r lags by r cycles so diagonals line up in the array
  for (genvar r = 0; r < SA_ROWS; r++) begin : g_row
    if (r == 0) begin : g_pass
      // row 0 enters the array directly
      assign skew_data[0 +: ACT_W] = in_data[0 +: ACT_W];
      assign skew_valid[0]         = in_valid;
    end else begin : g_dly
      act_t       dly_data [r];
      logic [r-1:0] dly_valid;

      // payload shift register, no reset
      always_ff @(posedge clk) begin
        dly_data[0] <= act_t'(in_data[r*ACT_W +: ACT_W]);
        for (int i = 1; i < r; i++) begin
          dly_data[i] <= dly_data[i-1];
        end
      end

      // valid travels beside the data
      always_ff @(posedge clk) begin
        if (rst) begin
          dly_valid <= '0;
        end else begin
          dly_valid[0] <= in_valid;
          for (int i = 1; i < r; i++) begin
            dly_valid[i] <= dly_valid[i-1];
          end
        end
      end

      // tap at depth r
      assign skew_data[r*ACT_W +: ACT_W] = dly_data[r-1];
      assign skew_valid[r]               = dly_valid[r-1];
    end
  end

endmodule

`default_nettype wire

/* hdl/sa_pkg.sv */
`default_nettype none

package sa_pkg;

  ////////////////////
  // array geometry
  ////////////////////
  localparam int SA_ROWS = 4;
  localparam int SA_COLS = 4;

  // element widths
  localparam int ACT_W   = 8;
  localparam int WT_W    = 8;
  // 16b product + 2b growth over 4 rows + 2b headroom
  localparam int ACC_W   = 20;
  localparam int OUT_W   = 8;
  localparam int ROW_W   = 2;
  localparam int SHIFT_W = 5;

  // rounding datapath, wide enough for half lsb at max shift
  localparam int RND_W   = ACC_W + (1 << SHIFT_W);

  // signed output clamp limits
  localparam int OUT_MAX = (1 << (OUT_W - 1)) - 1;
  localparam int OUT_MIN = -(1 << (OUT_W - 1));

  ////////////////////
  // types
  ////////////////////
  typedef logic signed [ACT_W-1:0]         act_t;
  typedef logic signed [WT_W-1:0]          wt_t;
  typedef logic signed [ACC_W-1:0]         acc_t;
  // element r at slice r
  typedef logic [SA_ROWS*ACT_W-1:0]        act_vec_t;
  // element c at slice c
  typedef logic [SA_COLS*WT_W-1:0]         wt_row_t;
  typedef logic [SA_COLS*ACC_W-1:0]        acc_vec_t;
  typedef logic [SA_COLS*OUT_W-1:0]        out_vec_t;
  typedef logic [ROW_W-1:0]                row_idx_t;
  typedef logic [SHIFT_W-1:0]              shift_t;

endpackage

`default_nettype wire
